// ==== Bender.yml ====
package:
  name: jtag_codec

sources:
  - rtl/jtag_pkg.sv
  - rtl/jtag_ctrl_if.sv
  - rtl/jtag_tap_fsm.sv
  - rtl/jtag_ir.sv
  - rtl/jtag_dr_bank.sv
  - rtl/jtag_tdo_stage.sv
  - rtl/jtag_codec.sv
  - target: simulation
    files:
      - sim/jtag_checker.sv
      - sim/tb_jtag_codec.sv

// ==== jtag_codec.f ====
rtl/jtag_pkg.sv
rtl/jtag_ctrl_if.sv
rtl/jtag_tap_fsm.sv
rtl/jtag_ir.sv
rtl/jtag_dr_bank.sv
rtl/jtag_tdo_stage.sv
rtl/jtag_codec.sv
sim/jtag_checker.sv
sim/tb_jtag_codec.sv

// ==== rtl/jtag_codec.sv ====
// JTAG TAP top level
`timescale 1ns/1ps

module jtag_codec import jtag_pkg::*; (
    input  logic                  tck,
    input  logic                  trst_n,
    input  logic                  tms,
    input  logic                  tdi,
    input  logic [USER_WIDTH-1:0] user_din,
    output logic                  tdo,
    output logic                  tdo_oe,
    output logic [USER_WIDTH-1:0] user_dout
);

    jtag_instr_e ir_op;
    logic        ir_so;
    logic        dr_so;

    jtag_ctrl_if ctrl_bus ();

    jtag_tap_fsm tap_fsm_inst (
        .tck    (tck),
        .trst_n (trst_n),
        .tms    (tms),
        .ctrl   (ctrl_bus.tap),
        .tdo_oe (tdo_oe)
    );

    jtag_ir ir_inst (
        .tck    (tck),
        .trst_n (trst_n),
        .tdi    (tdi),
        .ctrl   (ctrl_bus.ir),
        .ir_op  (ir_op),
        .ir_so  (ir_so)
    );

    jtag_dr_bank dr_bank_inst (
        .tck       (tck),
        .trst_n    (trst_n),
        .tdi       (tdi),
        .ctrl      (ctrl_bus.dr),
        .ir_op     (ir_op),
        .user_din  (user_din),
        .user_dout (user_dout),
        .dr_so     (dr_so)
    );

    jtag_tdo_stage tdo_stage_inst (
        .tck    (tck),
        .trst_n (trst_n),
        .ctrl   (ctrl_bus.out),
        .ir_so  (ir_so),
        .dr_so  (dr_so),
        .tdo    (tdo)
    );

endmodule

// ==== rtl/jtag_ctrl_if.sv ====
// TAP control strobes
`timescale 1ns/1ps

interface jtag_ctrl_if;

    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
    logic tlr;          // Level, high while in Test-Logic-Reset

    modport tap (
        output capture_dr, shift_dr, update_dr,
        output capture_ir, shift_ir, update_ir, tlr
    );

    modport ir (input capture_ir, shift_ir, update_ir, tlr);

    modport dr (input capture_dr, shift_dr, update_dr);

    modport out (input shift_ir, shift_dr);

endinterface

// ==== rtl/jtag_dr_bank.sv ====
// JTAG data register bank
`timescale 1ns/1ps

module jtag_dr_bank import jtag_pkg::*; (
    input  logic                  tck,
    input  logic                  trst_n,
    input  logic                  tdi,
    jtag_ctrl_if.dr               ctrl,
    input  jtag_instr_e           ir_op,
    input  logic [USER_WIDTH-1:0] user_din,
    output logic [USER_WIDTH-1:0] user_dout,
    output logic                  dr_so
);

    logic                    bypass_reg;
    logic [IDCODE_WIDTH-1:0] idcode_sr;
    logic [USER_WIDTH-1:0]   user_sr;
    logic                    sel_idcode;
    logic                    sel_user;
    logic                    sel_bypass;

    // Undefined opcodes fall back to bypass
    assign sel_idcode = (ir_op == INSTR_IDCODE);
    assign sel_user   = (ir_op == INSTR_USER);
    assign sel_bypass = !sel_idcode && !sel_user;

    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n)
            bypass_reg <= 1'b0;
        else if (sel_bypass && ctrl.capture_dr)
            bypass_reg <= 1'b0;             // Bypass captures zero
        else if (sel_bypass && ctrl.shift_dr)
            bypass_reg <= tdi;
    end

    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n)
            idcode_sr <= '0;
        else if (sel_idcode && ctrl.capture_dr)
            idcode_sr <= IDCODE_VALUE;
        else if (sel_idcode && ctrl.shift_dr)
            idcode_sr <= {tdi, idcode_sr[IDCODE_WIDTH-1:1]};
    end

    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n)
            user_sr <= '0;
        else if (sel_user && ctrl.capture_dr)
            user_sr <= user_din;
        else if (sel_user && ctrl.shift_dr)
            user_sr <= {tdi, user_sr[USER_WIDTH-1:1]};
    end

    // Parallel output only moves on Update-DR
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n)
            user_dout <= '0;
        else if (sel_user && ctrl.update_dr)
            user_dout <= user_sr;
    end

    always_comb begin
        case (ir_op)
            INSTR_IDCODE: dr_so = idcode_sr[0];
            INSTR_USER:   dr_so = user_sr[0];
            default:      dr_so = bypass_reg;
        endcase
    end

endmodule

// ==== rtl/jtag_ir.sv ====
// JTAG instruction register
`timescale 1ns/1ps

module jtag_ir import jtag_pkg::*; (
    input  logic        tck,
    input  logic        trst_n,
    input  logic        tdi,
    jtag_ctrl_if.ir     ctrl,
    output jtag_instr_e ir_op,
    output logic        ir_so
);

    logic [IR_WIDTH-1:0] ir_shift;

    // Shift stage, tdi in at the MSB
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n)
            ir_shift <= '0;
        else if (ctrl.capture_ir)
            ir_shift <= IR_CAPTURE;
        else if (ctrl.shift_ir)
            ir_shift <= {tdi, ir_shift[IR_WIDTH-1:1]};
    end

    // Update latch
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n)
            ir_op <= INSTR_IDCODE;
        else if (ctrl.tlr)
            ir_op <= INSTR_IDCODE;  // Test-Logic-Reset wins over update
        else if (ctrl.update_ir)
            ir_op <= jtag_instr_e'(ir_shift);
    end

    assign ir_so = ir_shift[0];

    // Update-IR only follows Exit1/Exit2, never overlaps Shift-IR
    a_no_update_during_shift: assert property (@(posedge tck) disable iff (!trst_n)
        !(ctrl.update_ir && ctrl.shift_ir));

endmodule

// ==== rtl/jtag_pkg.sv ====
// JTAG TAP shared definitions
package jtag_pkg;

    localparam int IR_WIDTH     = 4;
    localparam int USER_WIDTH   = 16;
    localparam int IDCODE_WIDTH = 32;

    // Loaded into the IR shift stage in Capture-IR, low bits fixed at 01
    localparam logic [IR_WIDTH-1:0] IR_CAPTURE = 4'b0101;

    // Device identification, bit 0 must be 1
    localparam logic [IDCODE_WIDTH-1:0] IDCODE_VALUE = 32'h1A5B_C0DF;

    // One-hot TAP states
    typedef enum logic [15:0] {
        TEST_LOGIC_RESET = 16'b0000_0000_0000_0001,
        RUN_TEST_IDLE    = 16'b0000_0000_0000_0010,
        SELECT_DR_SCAN   = 16'b0000_0000_0000_0100,
        CAPTURE_DR       = 16'b0000_0000_0000_1000,
        SHIFT_DR         = 16'b0000_0000_0001_0000,
        EXIT1_DR         = 16'b0000_0000_0010_0000,
        PAUSE_DR         = 16'b0000_0000_0100_0000,
        EXIT2_DR         = 16'b0000_0000_1000_0000,
        UPDATE_DR        = 16'b0000_0001_0000_0000,
        SELECT_IR_SCAN   = 16'b0000_0010_0000_0000,
        CAPTURE_IR       = 16'b0000_0100_0000_0000,
        SHIFT_IR         = 16'b0000_1000_0000_0000,
        EXIT1_IR         = 16'b0001_0000_0000_0000,
        PAUSE_IR         = 16'b0010_0000_0000_0000,
        EXIT2_IR         = 16'b0100_0000_0000_0000,
        UPDATE_IR        = 16'b1000_0000_0000_0000
    } tap_state_e;

    // Instruction opcodes, anything else acts as BYPASS
    typedef enum logic [IR_WIDTH-1:0] {
        INSTR_IDCODE = 4'h1,
        INSTR_USER   = 4'h8,
        INSTR_BYPASS = 4'hF
    } jtag_instr_e;

endpackage

// ==== rtl/jtag_tap_fsm.sv ====
// TAP state machine
`timescale 1ns/1ps

module jtag_tap_fsm import jtag_pkg::*; (
    input  logic   tck,
    input  logic   trst_n,
    input  logic   tms,
    jtag_ctrl_if.tap ctrl,
    output logic   tdo_oe
);

    logic       tms_ff;
    tap_state_e state;
    tap_state_e next_state;

    // TMS is sampled once before it steers the state
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n)
            tms_ff <= 1'b1;     // TMS idles high, so the TAP holds Test-Logic-Reset
        else
            tms_ff <= tms;
    end

    always_comb begin
        case (state)
            TEST_LOGIC_RESET: next_state = tms_ff ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    next_state = tms_ff ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   next_state = tms_ff ? SELECT_IR_SCAN   : CAPTURE_DR;
            CAPTURE_DR:       next_state = tms_ff ? EXIT1_DR         : SHIFT_DR;
            SHIFT_DR:         next_state = tms_ff ? EXIT1_DR         : SHIFT_DR;
            EXIT1_DR:         next_state = tms_ff ? UPDATE_DR        : PAUSE_DR;
            PAUSE_DR:         next_state = tms_ff ? EXIT2_DR         : PAUSE_DR;
            EXIT2_DR:         next_state = tms_ff ? UPDATE_DR        : SHIFT_DR;
            UPDATE_DR:        next_state = tms_ff ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            SELECT_IR_SCAN:   next_state = tms_ff ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       next_state = tms_ff ? EXIT1_IR         : SHIFT_IR;
            SHIFT_IR:         next_state = tms_ff ? EXIT1_IR         : SHIFT_IR;
            EXIT1_IR:         next_state = tms_ff ? UPDATE_IR        : PAUSE_IR;
            PAUSE_IR:         next_state = tms_ff ? EXIT2_IR         : PAUSE_IR;
            EXIT2_IR:         next_state = tms_ff ? UPDATE_IR        : SHIFT_IR;
            UPDATE_IR:        next_state = tms_ff ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            default:          next_state = TEST_LOGIC_RESET; // Recover from a corrupt state
        endcase
    end

    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n)
            state <= TEST_LOGIC_RESET;
        else
            state <= next_state;
    end

    // Strobes lag the state by one cycle
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            ctrl.capture_dr <= 1'b0;
            ctrl.shift_dr   <= 1'b0;
            ctrl.update_dr  <= 1'b0;
            ctrl.capture_ir <= 1'b0;
            ctrl.shift_ir   <= 1'b0;
            ctrl.update_ir  <= 1'b0;
            ctrl.tlr        <= 1'b1;    // Reset state is Test-Logic-Reset
            tdo_oe          <= 1'b0;
        end else begin
            ctrl.capture_dr <= (state == CAPTURE_DR);
            ctrl.shift_dr   <= (state == SHIFT_DR);
            ctrl.update_dr  <= (state == UPDATE_DR);
            ctrl.capture_ir <= (state == CAPTURE_IR);
            ctrl.shift_ir   <= (state == SHIFT_IR);
            ctrl.update_ir  <= (state == UPDATE_IR);
            ctrl.tlr        <= (state == TEST_LOGIC_RESET);
            tdo_oe          <= (state == SHIFT_DR) || (state == SHIFT_IR);
        end
    end

    a_state_onehot: assert property (@(posedge tck) disable iff (!trst_n)
        $onehot(state));

    a_strobe_onehot0: assert property (@(posedge tck) disable iff (!trst_n)
        $onehot0({ctrl.capture_dr, ctrl.shift_dr, ctrl.update_dr,
                  ctrl.capture_ir, ctrl.shift_ir, ctrl.update_ir}));

endmodule

// ==== rtl/jtag_tdo_stage.sv ====
// TDO output stage
`timescale 1ns/1ps

module jtag_tdo_stage (
    input  logic     tck,
    input  logic     trst_n,
    jtag_ctrl_if.out ctrl,
    input  logic     ir_so,
    input  logic     dr_so,
    output logic     tdo
);

    logic tdo_next;

    assign tdo_next = ctrl.shift_ir ? ir_so : dr_so;

    // Falling edge retiming, bit is stable at the next rising edge
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n)
            tdo <= 1'b0;
        else
            tdo <= tdo_next;
    end

    // The IR and DR paths never shift at once
    a_single_shift: assert property (@(posedge tck) disable iff (!trst_n)
        !(ctrl.shift_ir && ctrl.shift_dr));

endmodule

// ==== sim/jtag_checker.sv ====
// Scan response checker
`timescale 1ns/1ps

module jtag_checker (
    input  logic        tck,
    input  logic        trst_n,
    input  logic        tdo,
    input  logic        tdo_oe,
    input  logic [15:0] user_dout,
    input  logic        check_req,
    input  int          test_id,
    input  int          scan_kind,      // 0 IR scan, 1 DR scan, 2 TMS reset
    input  int          exp_len,
    input  logic [31:0] exp_word,
    input  logic [15:0] exp_user,
    output int          pass_count,
    output int          fail_count
);

    logic [31:0] got_word;
    int          bit_count;

    function automatic string kind_name(input int kind);
        case (kind)
            0:       return "IR scan";
            1:       return "DR scan";
            default: return "TMS reset";
        endcase
    endfunction

    // Judges one finished scan and prints its result line
    task automatic judge_scan();
        logic [31:0] mask;
        mask = (exp_len >= 32) ? 32'hFFFF_FFFF : ((32'h1 << exp_len) - 1);
        if (bit_count != exp_len) begin
            $display("test %0d %s failed: tdo_oe was high for %0d cycles instead of %0d",
                     test_id, kind_name(scan_kind), bit_count, exp_len);
            fail_count++;
        end else if ((got_word & mask) !== (exp_word & mask)) begin
            $display("ERROR test %0d %s: tdo got 0x%08h expected 0x%08h",
                     test_id, kind_name(scan_kind), got_word & mask, exp_word & mask);
            fail_count++;
        end else if (user_dout !== exp_user) begin
            $display("ERROR test %0d %s: user_dout got 0x%04h expected 0x%04h",
                     test_id, kind_name(scan_kind), user_dout, exp_user);
            fail_count++;
        end else begin
            $display("PASS test %0d %s", test_id, kind_name(scan_kind));
            pass_count++;
        end
    endtask

    // TDO bits leave LSB first, one per rising edge with tdo_oe high
    always @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            got_word   <= '0;
            bit_count  <= 0;
            pass_count = 0;
            fail_count = 0;
        end else if (check_req) begin
            judge_scan();
            got_word  <= '0;
            bit_count <= 0;
        end else if (tdo_oe) begin
            if (bit_count < 32)
                got_word[bit_count] <= tdo;
            bit_count <= bit_count + 1;
        end
    end

endmodule

// ==== sim/tb_jtag_codec.sv ====
// JTAG TAP testbench
`timescale 1ns/1ps

module tb_jtag_codec import jtag_pkg::*; ();

    localparam int NUM_ROWS        = 10;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 80 + 200;
    localparam int KIND_IR         = 0;     // Scan kinds as jtag_checker numbers them
    localparam int KIND_DR         = 1;
    localparam int KIND_RESET      = 2;

    typedef enum logic [1:0] {ROW_DR, ROW_IR_DR, ROW_PAUSE_DR, ROW_RESET_DR} row_kind_e;

    typedef struct packed {
        row_kind_e   kind;
        logic [3:0]  opcode;
        logic [5:0]  len;
        logic [31:0] din;
        logic [15:0] user_din;
        logic [31:0] exp_dr;
        logic [15:0] exp_user;
    } scan_row_t;

    logic                  tck       = 1'b0;
    logic                  trst_n    = 1'b0;
    logic                  tms       = 1'b1;
    logic                  tdi       = 1'b0;
    logic [USER_WIDTH-1:0] user_din  = '0;
    logic                  tdo;
    logic                  tdo_oe;
    logic [USER_WIDTH-1:0] user_dout;

    logic                  check_req = 1'b0;
    int                    test_id   = 0;
    int                    scan_kind = 0;
    int                    exp_len   = 0;
    logic [31:0]           exp_word  = '0;
    logic [USER_WIDTH-1:0] exp_user  = '0;
    int                    pass_count;
    int                    fail_count;
    int                    checks_issued = 0;

    scan_row_t             rows [NUM_ROWS];
    int                    row_count  = 0;
    logic [3:0]            model_op   = INSTR_IDCODE;   // Opcode the DUT should hold
    logic [USER_WIDTH-1:0] model_user = '0;
    logic [31:0]           shift_word = '0;
    int                    shift_idx  = 0;

    always #50 tck = ~tck;

    jtag_codec jtag_codec_inst (
        .tck       (tck),
        .trst_n    (trst_n),
        .tms       (tms),
        .tdi       (tdi),
        .user_din  (user_din),
        .tdo       (tdo),
        .tdo_oe    (tdo_oe),
        .user_dout (user_dout)
    );

    jtag_checker response_check (
        .tck        (tck),
        .trst_n     (trst_n),
        .tdo        (tdo),
        .tdo_oe     (tdo_oe),
        .user_dout  (user_dout),
        .check_req  (check_req),
        .test_id    (test_id),
        .scan_kind  (scan_kind),
        .exp_len    (exp_len),
        .exp_word   (exp_word),
        .exp_user   (exp_user),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    // Appends one row and works out its expected responses
    task automatic add_row(input row_kind_e kind, input logic [3:0] op, input int len,
                           input logic [31:0] din, input logic [15:0] udin);
        logic [31:0] mask;
        logic [31:0] exp;
        mask = (len >= 32) ? 32'hFFFF_FFFF : ((32'h1 << len) - 1);
        if (kind == ROW_RESET_DR)
            model_op = INSTR_IDCODE;
        else if (kind != ROW_DR)
            model_op = op;
        if (model_op == INSTR_IDCODE) begin
            exp = IDCODE_VALUE;
        end else if (model_op == INSTR_USER) begin
            exp        = {16'h0, udin};
            model_user = din[15:0];     // Lands on user_dout at Update-DR
        end else begin
            exp = (din << 1) & mask;    // Bypass gives 0, then tdi one bit late
        end
        rows[row_count].kind     = kind;
        rows[row_count].opcode   = op;
        rows[row_count].len      = 6'(len);
        rows[row_count].din      = din;
        rows[row_count].user_din = udin;
        rows[row_count].exp_dr   = exp;
        rows[row_count].exp_user = model_user;
        row_count++;
    endtask

    // One TAP step, tdi follows tdo_oe so alignment never depends on latency
    task automatic clock_tms(input logic t);
        @(negedge tck);
        tms = t;
        if (tdo_oe) begin
            tdi = shift_word[shift_idx % 32];
            shift_idx++;
        end
    endtask

    task automatic scan_tap(input logic is_ir, input int len, input logic [31:0] din,
                            input int pause_at);
        shift_word = din;
        shift_idx  = 0;
        clock_tms(1'b1);                    // Select-DR-Scan
        if (is_ir)
            clock_tms(1'b1);                // Select-IR-Scan
        clock_tms(1'b0);                    // Capture
        clock_tms(1'b0);                    // First Shift cycle
        for (int i = 1; i < len; i++) begin
            if (i == pause_at) begin
                clock_tms(1'b1);            // Exit1
                clock_tms(1'b0);            // Pause
                clock_tms(1'b0);
                clock_tms(1'b1);            // Exit2
            end
            clock_tms(1'b0);
        end
        clock_tms(1'b1);                    // Exit1
        clock_tms(1'b1);                    // Update
        repeat (4) clock_tms(1'b0);         // Run-Test-Idle plus the TMS to strobe delay
    endtask

    // Five ones reach Test-Logic-Reset from any state
    task automatic tms_reset();
        repeat (5) clock_tms(1'b1);
        repeat (4) clock_tms(1'b0);
    endtask

    task automatic request_check(input int id, input int kind, input int len,
                                 input logic [31:0] word, input logic [15:0] user);
        @(negedge tck);
        test_id   = id;
        scan_kind = kind;
        exp_len   = len;
        exp_word  = word;
        exp_user  = user;
        check_req = 1'b1;
        @(negedge tck);
        check_req = 1'b0;
        checks_issued++;
    endtask

    initial begin
        int                    seed;
        int                    pause_at;
        logic [USER_WIDTH-1:0] prev_user;
        seed = $urandom(97);
        add_row(ROW_DR,       4'h0,         32, $urandom,      16'h0000); // Reset IDCODE
        add_row(ROW_IR_DR,    INSTR_BYPASS, 8,  $urandom,      16'h0000);
        add_row(ROW_IR_DR,    4'h3,         12, $urandom,      16'h0000); // Undefined opcode
        add_row(ROW_IR_DR,    INSTR_USER,   16, $urandom,      16'hA5C3);
        add_row(ROW_DR,       4'h0,         16, $urandom,      16'h3C5A);
        add_row(ROW_IR_DR,    INSTR_BYPASS, 5,  $urandom,      16'h0000);
        add_row(ROW_RESET_DR, 4'h0,         32, $urandom,      16'h0000);
        add_row(ROW_IR_DR,    INSTR_USER,   16, 32'h0000_C0DE, 16'h1234);
        add_row(ROW_DR,       4'h0,         16, $urandom,      16'h5678);
        add_row(ROW_PAUSE_DR, INSTR_USER,   16, 32'h0000_C0DE, 16'h9ABC);
        prev_user = '0;
        repeat (10) @(negedge tck);
        trst_n = 1'b1;
        repeat (2) clock_tms(1'b0);         // Leave Test-Logic-Reset
        for (int r = 0; r < row_count; r++) begin
            if (rows[r].kind == ROW_IR_DR || rows[r].kind == ROW_PAUSE_DR) begin
                scan_tap(1'b1, IR_WIDTH, {28'h0, rows[r].opcode}, 0);
                request_check(r, KIND_IR, IR_WIDTH, {28'h0, IR_CAPTURE}, prev_user);
            end else if (rows[r].kind == ROW_RESET_DR) begin
                tms_reset();
                request_check(r, KIND_RESET, 0, 32'h0, prev_user);
            end
            user_din = rows[r].user_din;
            pause_at = (rows[r].kind == ROW_PAUSE_DR) ? rows[r].len / 2 : 0;
            scan_tap(1'b0, rows[r].len, rows[r].din, pause_at);
            request_check(r, KIND_DR, rows[r].len, rows[r].exp_dr, rows[r].exp_user);
            prev_user = rows[r].exp_user;
        end
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count == checks_issued)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge tck);
        $display("Timeout: the scans did not finish within %0d tck cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
